// ==== Makefile ====
# Verilator simulation of the fetch redirect slice
# Run from the project root so the testbench finds its pattern file

TOP = fetch_redirect_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f fetch_redirect.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== fetch_redirect.f ====
+incdir+hdl
hdl/rv_branch_pkg.sv
hdl/branch_compare.sv
hdl/branch_ctrl_unit.sv
hdl/pc_next.sv
hdl/fetch_port.sv
hdl/fetch_redirect.sv
tests/fetch_redirect_tb.sv

// ==== hdl/branch_compare.sv ====
//**************************************************************************
// Execute stage operand compare with its register stage
// Produces zero and less than flags plus the decision inputs one cycle late
//**************************************************************************

`timescale 1ns/10ps

`include "rv_branch_consts.svh"

module branch_compare
    import rv_branch_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_ex_valid,     // Control flow instruction present
    input  logic                    i_branch,
    input  logic                    i_jump,
    input  logic                    i_link_reg,     // JALR when set with jump
    input  logic [`RV_FUNC3_W-1:0]  i_func3,
    input  logic [`RV_XLEN-1:0]     i_rs1,
    input  logic [`RV_XLEN-1:0]     i_rs2,
    input  logic [`RV_XLEN-1:0]     i_ex_pc,
    input  logic [`RV_XLEN-1:0]     i_imm,
    output logic                    o_valid,
    output logic                    o_branch,
    output logic                    o_jump,
    output logic                    o_link_reg,
    output br_func3_e               o_func3,
    output logic                    o_zero,         // rs1 equals rs2
    output logic                    o_less,         // rs1 below rs2
    output logic [`RV_XLEN-1:0]     o_pc,
    output logic [`RV_XLEN-1:0]     o_rs1,
    output logic [`RV_XLEN-1:0]     o_imm
);

    logic less_cmp;

    // BLTU and BGEU have func3 bit 1 set
    assign less_cmp = i_func3[1] ? (i_rs1 < i_rs2)
                                 : ($signed(i_rs1) < $signed(i_rs2));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_ex_valid;
        end
    end

    // Flags and decision payload, qualified by o_valid downstream
    always_ff @(posedge clk) begin
        o_branch   <= i_branch;
        o_jump     <= i_jump;
        o_link_reg <= i_link_reg;
        o_func3    <= br_func3_e'(i_func3);
        o_zero     <= (i_rs1 == i_rs2);
        o_less     <= less_cmp;
        o_pc       <= i_ex_pc;
        o_rs1      <= i_rs1;
        o_imm      <= i_imm;
    end

endmodule

// ==== hdl/branch_ctrl_unit.sv ====
//**************************************************************************
// Branch control unit that picks the next PC source from registered flags
// Purely combinational and sits right after the compare register stage
//**************************************************************************

`timescale 1ns/10ps

module branch_ctrl_unit
    import rv_branch_pkg::*;
(
    input  logic        i_valid,        // Registered instruction valid
    input  logic        i_branch,       // Conditional branch
    input  logic        i_jump,         // JAL or JALR
    input  logic        i_link_reg,     // Selects JALR over JAL
    input  br_func3_e   i_func3,
    input  logic        i_zero,         // Operands equal
    input  logic        i_less,         // rs1 below rs2 in the order func3 asks for
    output pc_src_e     o_pc_src,
    output logic        o_flush         // Kill younger stages and redirect fetch
);

    logic cond_taken;

    // Branch condition from the two compare flags
    always_comb begin
        cond_taken = 1'b0;
        case (i_func3)
            BEQ:     cond_taken = i_zero;
            BNE:     cond_taken = !i_zero;
            BLT:     cond_taken = i_less;       // Signed compare
            BGE:     cond_taken = !i_less;
            BLTU:    cond_taken = i_less;       // Unsigned compare
            BGEU:    cond_taken = !i_less;
            default: cond_taken = 1'b0;         // Reserved encodings never branch
        endcase
    end

    // Branch first, then JAL, then JALR
    always_comb begin
        o_pc_src = PC_SEQ;                      // Predicted path by default
        if (i_valid) begin
            if (i_branch) begin
                if (cond_taken) begin
                    o_pc_src = PC_REL;
                end
            end else if (i_jump && !i_link_reg) begin
                o_pc_src = PC_REL;              // JAL
            end else if (i_jump && i_link_reg) begin
                o_pc_src = PC_REG;              // JALR
            end
        end
    end

    // Every non sequential source is a mispredict
    // Fetch assumed not taken
    assign o_flush = (o_pc_src != PC_SEQ);

endmodule

// ==== hdl/fetch_port.sv ====
//**************************************************************************
// Instruction memory port with a four phase req and ack handshake
// Fetches at the current PC and throws away words from a flushed path
//**************************************************************************

`timescale 1ns/10ps

`include "rv_branch_consts.svh"

module fetch_port
    import rv_branch_pkg::*;
(
    input  logic                clk,
    input  logic                i_reset,
    input  logic [`RV_XLEN-1:0] i_pc,           // Address to fetch next
    input  logic                i_flush,        // Redirect in this cycle
    input  logic                i_imem_ack,
    input  logic [`RV_XLEN-1:0] i_imem_rdata,
    output logic                o_imem_req,
    output logic [`RV_XLEN-1:0] o_imem_addr,    // Held stable while req is high
    output logic [`RV_XLEN-1:0] o_instr,
    output logic [`RV_XLEN-1:0] o_instr_addr,   // Address o_instr came from
    output logic                o_instr_valid,  // One cycle per delivered word
    output logic                o_fetch_done    // Tells pc_next to step
);

    fetch_state_e state;
    logic         launch;       // Start a new request this cycle
    logic         capture;      // Live word returned this cycle

    // Wait for ack low from the last transfer
    // Skip the flush cycle since the PC only turns to the target next cycle
    assign launch  = (state == F_IDLE) && !i_imem_ack && !i_flush;
    assign capture = (state == F_REQ) && i_imem_ack;

    assign o_imem_req   = (state != F_IDLE);
    assign o_fetch_done = capture;              // pc_next lets a flush win

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= F_IDLE;
        end else begin
            case (state)
                F_IDLE: begin
                    if (launch) state <= F_REQ;
                end
                F_REQ: begin
                    if (i_imem_ack) state <= F_IDLE;    // Drop req and wait for ack low
                    else if (i_flush) state <= F_DROP;  // Old path now in flight
                end
                F_DROP: begin
                    if (i_imem_ack) state <= F_IDLE;    // Word ignored
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // Address latched at launch and held through the handshake
    always_ff @(posedge clk) begin
        if (launch) o_imem_addr <= i_pc;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_instr_valid <= 1'b0;
        end else begin
            o_instr_valid <= capture && !i_flush;   // Same cycle flush kills it
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_instr      <= i_imem_rdata;
            o_instr_addr <= o_imem_addr;
        end
    end

endmodule

// ==== hdl/fetch_redirect.sv ====
//**************************************************************************
// Top level of the branch resolution and fetch redirect slice
// Chains compare, branch control, next PC and the instruction memory port
//**************************************************************************

`timescale 1ns/10ps

`include "rv_branch_consts.svh"

module fetch_redirect
    import rv_branch_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_ex_valid,
    input  logic                    i_branch,
    input  logic                    i_jump,
    input  logic                    i_link_reg,
    input  logic [`RV_FUNC3_W-1:0]  i_func3,
    input  logic [`RV_XLEN-1:0]     i_rs1,
    input  logic [`RV_XLEN-1:0]     i_rs2,
    input  logic [`RV_XLEN-1:0]     i_ex_pc,
    input  logic [`RV_XLEN-1:0]     i_imm,
    input  logic                    i_imem_ack,
    input  logic [`RV_XLEN-1:0]     i_imem_rdata,
    output logic                    o_flush,
    output logic [`RV_XLEN-1:0]     o_target,
    output logic                    o_imem_req,
    output logic [`RV_XLEN-1:0]     o_imem_addr,
    output logic [`RV_XLEN-1:0]     o_instr,
    output logic [`RV_XLEN-1:0]     o_instr_addr,
    output logic                    o_instr_valid
);

    logic                r_valid, r_branch, r_jump, r_link_reg;
    br_func3_e           r_func3;
    logic                r_zero, r_less;
    logic [`RV_XLEN-1:0] r_pc, r_rs1, r_imm;
    pc_src_e             pc_src;
    logic [`RV_XLEN-1:0] fetch_pc;
    logic                fetch_done;

    // Register stage gives the one cycle to flush
    branch_compare branch_compare_i (
        .clk(clk), .i_reset(i_reset),
        .i_ex_valid(i_ex_valid), .i_branch(i_branch), .i_jump(i_jump),
        .i_link_reg(i_link_reg), .i_func3(i_func3), .i_rs1(i_rs1), .i_rs2(i_rs2),
        .i_ex_pc(i_ex_pc), .i_imm(i_imm),
        .o_valid(r_valid), .o_branch(r_branch), .o_jump(r_jump),
        .o_link_reg(r_link_reg), .o_func3(r_func3), .o_zero(r_zero), .o_less(r_less),
        .o_pc(r_pc), .o_rs1(r_rs1), .o_imm(r_imm)
    );

    branch_ctrl_unit branch_ctrl_unit_i (
        .i_valid(r_valid), .i_branch(r_branch), .i_jump(r_jump),
        .i_link_reg(r_link_reg), .i_func3(r_func3), .i_zero(r_zero), .i_less(r_less),
        .o_pc_src(pc_src), .o_flush(o_flush)
    );

    pc_next pc_next_i (
        .clk(clk), .i_reset(i_reset), .i_pc_src(pc_src),
        .i_ex_pc(r_pc), .i_rs1(r_rs1), .i_imm(r_imm),
        .i_fetch_done(fetch_done), .o_pc(fetch_pc), .o_target(o_target)
    );

    fetch_port fetch_port_i (
        .clk(clk), .i_reset(i_reset), .i_pc(fetch_pc), .i_flush(o_flush),
        .i_imem_ack(i_imem_ack), .i_imem_rdata(i_imem_rdata),
        .o_imem_req(o_imem_req), .o_imem_addr(o_imem_addr),
        .o_instr(o_instr), .o_instr_addr(o_instr_addr),
        .o_instr_valid(o_instr_valid), .o_fetch_done(fetch_done)
    );

endmodule

// ==== hdl/pc_next.sv ====
//**************************************************************************
// Fetch PC register with redirect target generation
// Steps by one instruction per completed fetch and loads the target on flush
//**************************************************************************

`timescale 1ns/10ps

`include "rv_branch_consts.svh"

module pc_next
    import rv_branch_pkg::*;
(
    input  logic                clk,
    input  logic                i_reset,
    input  pc_src_e             i_pc_src,       // From the branch control unit
    input  logic [`RV_XLEN-1:0] i_ex_pc,        // PC of the resolved instruction
    input  logic [`RV_XLEN-1:0] i_rs1,
    input  logic [`RV_XLEN-1:0] i_imm,
    input  logic                i_fetch_done,   // Fetch port got its word
    output logic [`RV_XLEN-1:0] o_pc,           // Address of the next fetch
    output logic [`RV_XLEN-1:0] o_target        // Redirect address
);

    logic [`RV_XLEN-1:0] rel_target;
    logic [`RV_XLEN-1:0] reg_sum;
    logic [`RV_XLEN-1:0] reg_target;
    logic                redirect;

    assign rel_target = i_ex_pc + i_imm;                    // Branches and JAL
    assign reg_sum    = i_rs1 + i_imm;
    assign reg_target = {reg_sum[`RV_XLEN-1:1], 1'b0};      // JALR drops bit 0

    always_comb begin
        case (i_pc_src)
            PC_REG:  o_target = reg_target;
            default: o_target = rel_target;     // Only looked at during a flush
        endcase
    end

    assign redirect = (i_pc_src != PC_SEQ);

    // Redirect takes priority over the sequential step
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc <= `RV_RESET_PC;
        end else if (redirect) begin
            o_pc <= o_target;
        end else if (i_fetch_done) begin
            o_pc <= o_pc + `RV_INSTR_STEP;
        end
    end

endmodule

// ==== hdl/rv_branch_consts.svh ====
//**************************************************************************
// Widths and fixed values shared by the branch resolution and fetch logic
// Include in any file that sizes a datapath or resets the fetch PC
//**************************************************************************

`ifndef RV_BRANCH_CONSTS_SVH
`define RV_BRANCH_CONSTS_SVH

// Datapath and address width of the RV32I core
`define RV_XLEN 32

// Width of the func3 field in the instruction word
`define RV_FUNC3_W 3

// First fetch address once reset is released
`define RV_RESET_PC 32'h0000_0000

// Sequential step between instruction words
// Instructions are 4 bytes wide
`define RV_INSTR_STEP 32'd4

`endif

// ==== hdl/rv_branch_pkg.sv ====
//**************************************************************************
// Types for the branch resolution and fetch redirect logic
// Modules pull these in with a wildcard import in their header
//**************************************************************************

`include "rv_branch_consts.svh"

package rv_branch_pkg;

    // Where the next fetch PC comes from
    typedef enum logic [1:0] {
        PC_SEQ = 2'b00,     // PC + 4
        PC_REL = 2'b01,     // PC + imm for taken branches and JAL
        PC_REG = 2'b10      // rs1 + imm with bit 0 cleared for JALR
    } pc_src_e;

    // Conditional branch func3 encodings
    typedef enum logic [`RV_FUNC3_W-1:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_func3_e;

    // Instruction memory handshake states
    typedef enum logic [1:0] {
        F_IDLE = 2'b00,     // No request out and ack must be low before a new one
        F_REQ  = 2'b01,     // Request out and waiting for ack high
        F_DROP = 2'b10      // Flushed request out and its word will be thrown away
    } fetch_state_e;

endpackage

// ==== tests/fetch_redirect_patterns.txt ====
// name valid branch jump link_reg func3 rs1 rs2 ex_pc imm exp_flush exp_target
// All numeric fields in hex, exp_target only compared when exp_flush is 1
beq_taken       1 1 0 0 0 00000005 00000005 00000100 00000020 1 00000120
beq_not_taken   1 1 0 0 0 00000005 00000006 00000104 00000020 0 00000000
beq_zero_back   1 1 0 0 0 00000000 00000000 00000c00 fffffffc 1 00000bfc
bne_taken       1 1 0 0 1 00000005 00000006 00000108 fffffff0 1 000000f8
bne_not_taken   1 1 0 0 1 00000007 00000007 0000010c 00000040 0 00000000
bne_sign_bit    1 1 0 0 1 80000000 00000000 00000b00 00000040 1 00000b40
blt_neg_pos     1 1 0 0 4 ffffffff 00000001 00000200 00000008 1 00000208
blt_pos_neg     1 1 0 0 4 00000001 ffffffff 00000204 00000008 0 00000000
blt_both_neg    1 1 0 0 4 fffffff0 fffffffe 00000900 00000008 1 00000908
blt_equal       1 1 0 0 4 00000009 00000009 00000904 00000010 0 00000000
bge_pos_neg     1 1 0 0 5 00000001 ffffffff 00000300 00000010 1 00000310
bge_min_zero    1 1 0 0 5 80000000 00000000 00000304 00000010 0 00000000
bge_equal       1 1 0 0 5 00000003 00000003 00000400 00000004 1 00000404
bltu_small_big  1 1 0 0 6 00000001 ffffffff 00000500 00000100 1 00000600
bltu_big_small  1 1 0 0 6 ffffffff 00000001 00000504 00000100 0 00000000
bltu_both_high  1 1 0 0 6 fffffff0 fffffffe 00000a00 0000000c 1 00000a0c
bgeu_big_small  1 1 0 0 7 ffffffff 00000001 00000700 ffffff00 1 00000600
bgeu_zero_min   1 1 0 0 7 00000000 80000000 00000704 00000020 0 00000000
bgeu_equal      1 1 0 0 7 80000000 80000000 00000800 00000020 1 00000820
jal_forward     1 0 1 0 0 12345678 00000000 00001000 00000400 1 00001400
jal_backward    1 0 1 0 0 00000000 00000000 00002000 fffff000 1 00001000
jalr_aligned    1 0 1 1 0 00003000 00000000 00000040 00000004 1 00003004
jalr_odd_sum    1 0 1 1 0 00003001 00000000 00000044 00000004 1 00003004
jalr_bit0       1 0 1 1 0 00004000 00000000 00000048 00000003 1 00004002
jalr_negative   1 0 1 1 0 00005000 00000000 0000004c ffffffff 1 00004ffe
invalid_beq     0 1 0 0 0 00000005 00000005 00000100 00000020 0 00000000
invalid_jal     0 0 1 0 0 00000000 00000000 00001000 00000400 0 00000000
invalid_jalr    0 0 1 1 0 00003000 00000000 00000040 00000004 0 00000000
func3_010       1 1 0 0 2 00000001 00000002 00000600 00000010 0 00000000
func3_011       1 1 0 0 3 00000001 00000001 00000604 00000010 0 00000000
no_branch_jump  1 0 0 0 0 00000001 00000001 00000608 00000010 0 00000000
branch_over_jal 1 1 1 0 0 00000001 00000002 0000060c 00000010 0 00000000
branch_and_jal  1 1 1 0 0 00000002 00000002 00000610 00000010 1 00000620

// ==== tests/fetch_redirect_tb.sv ====
//**************************************************************************
// Testbench for the branch resolution and fetch redirect slice
// Replays control flow patterns from the data file against a modeled imem
// Run from the project root so the pattern file path resolves
//**************************************************************************

`timescale 1ns/10ps

`include "rv_branch_consts.svh"

module fetch_redirect_tb;

    localparam string PATTERN_FILE = "tests/fetch_redirect_patterns.txt";
    localparam int    CLK_PERIOD   = 8;

    logic                    clk;
    logic                    i_reset;
    logic                    i_ex_valid, i_branch, i_jump, i_link_reg;
    logic [`RV_FUNC3_W-1:0]  i_func3;
    logic [`RV_XLEN-1:0]     i_rs1, i_rs2, i_ex_pc, i_imm;
    logic                    i_imem_ack;
    logic [`RV_XLEN-1:0]     i_imem_rdata;
    logic                    o_flush, o_imem_req, o_instr_valid;
    logic [`RV_XLEN-1:0]     o_target, o_imem_addr, o_instr, o_instr_addr;

    string                   lines[$];              // Raw pattern lines
    bit                      loaded = 1'b0;
    int                      errors = 0;
    int                      checks = 0;
    int                      words = 0;             // Words seen on o_instr_valid
    logic [31:0]             lfsr_state = 32'ha39c5ac8;
    logic [`RV_XLEN-1:0]     expect_addr;           // Next address fetch must deliver
    logic [`RV_XLEN-1:0]     flush_target = '0;     // Target of the pattern in flight
    bit                      redirect_pending = 1'b0;

    fetch_redirect fetch_redirect_i (
        .clk(clk), .i_reset(i_reset),
        .i_ex_valid(i_ex_valid), .i_branch(i_branch), .i_jump(i_jump),
        .i_link_reg(i_link_reg), .i_func3(i_func3), .i_rs1(i_rs1), .i_rs2(i_rs2),
        .i_ex_pc(i_ex_pc), .i_imm(i_imm),
        .i_imem_ack(i_imem_ack), .i_imem_rdata(i_imem_rdata),
        .o_flush(o_flush), .o_target(o_target),
        .o_imem_req(o_imem_req), .o_imem_addr(o_imem_addr),
        .o_instr(o_instr), .o_instr_addr(o_instr_addr), .o_instr_valid(o_instr_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Right shifting Galois LFSR with taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'hA300_0000;
        return s >> 1;
    endfunction

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);     // One step per bit
        end
        return value;
    endfunction

    task automatic drive_idle();
        i_ex_valid = 1'b0;
        i_branch   = 1'b0;
        i_jump     = 1'b0;
        i_link_reg = 1'b0;
        i_func3    = '0;
        i_rs1      = '0;
        i_rs2      = '0;
        i_ex_pc    = '0;
        i_imm      = '0;
    endtask

    task automatic load_patterns();
        int    fd;
        string line;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the pattern file %s", PATTERN_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 1) != "//") begin
                    lines.push_back(line);          // Skip comments and blank lines
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    // One execute cycle, then flush and target checked one cycle later
    task automatic apply_pattern(input string line);
        string       tname;
        logic [31:0] v, br, jp, lk, f3, rs1, rs2, pc, imm, eflush, etarget;
        int          n;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", tname, v, br, jp, lk,
                    f3, rs1, rs2, pc, imm, eflush, etarget);
        if (n != 12) begin
            errors++;
            $display("Pattern line could not be parsed: %s", line);
        end else begin
            @(posedge clk);
            #1;
            i_ex_valid   = v[0];
            i_branch     = br[0];
            i_jump       = jp[0];
            i_link_reg   = lk[0];
            i_func3      = f3[2:0];
            i_rs1        = rs1;
            i_rs2        = rs2;
            i_ex_pc      = pc;
            i_imm        = imm;
            flush_target = etarget;                 // Fetch must resume here on a flush
            @(posedge clk);
            #1;
            drive_idle();                           // Decision stage holds the pattern now
            @(negedge clk);
            check(tname, {31'b0, eflush[0]}, {31'b0, o_flush});
            if (eflush[0]) check({tname, "_target"}, etarget, o_target);
        end
    endtask

    // Instruction memory with four phase handshake and a random ack delay of 0 to 3 cycles
    initial begin
        int wait_cnt;
        bit pending;
        wait_cnt     = 0;
        pending      = 1'b0;
        i_imem_ack   = 1'b0;
        i_imem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (i_reset) begin
                i_imem_ack = 1'b0;
                pending    = 1'b0;
            end else if (i_imem_ack) begin
                if (!o_imem_req) i_imem_ack = 1'b0;     // Req dropped so release ack
            end else if (o_imem_req) begin
                if (!pending) begin
                    pending  = 1'b1;
                    wait_cnt = random_bits(2);
                end
                if (wait_cnt == 0) begin
                    i_imem_ack   = 1'b1;
                    i_imem_rdata = ~o_imem_addr;        // Predictable data word
                    pending      = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // Fetch monitor for delivered words and handshake order
    initial begin
        bit prev_req;
        bit prev_ack;
        prev_req = 1'b0;
        prev_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (i_reset) begin
                expect_addr      = `RV_RESET_PC;
                redirect_pending = 1'b0;
            end else begin
                if (o_imem_req && !prev_req && prev_ack) begin
                    errors++;
                    $display("Request rose at %0t before ack was seen low", $time);
                end
                // Word first since it left memory before any flush in this cycle
                if (o_instr_valid) begin
                    check("instr_addr", expect_addr, o_instr_addr);
                    check("instr_data", ~expect_addr, o_instr);
                    expect_addr      = expect_addr + `RV_INSTR_STEP;
                    redirect_pending = 1'b0;
                    words++;
                end
                if (o_flush) begin
                    expect_addr      = flush_target;    // Old path must not show up again
                    redirect_pending = 1'b1;
                end
            end
            prev_req = o_imem_req;
            prev_ack = i_imem_ack;
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (lines.size() + 1) * 40;
        repeat (limit) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        i_reset = 1'b1;
        drive_idle();
        load_patterns();
        repeat (5) @(posedge clk);
        #1;
        i_reset = 1'b0;
        repeat (20) @(posedge clk);                 // Sequential fetch from the reset PC
        foreach (lines[idx]) begin
            apply_pattern(lines[idx]);
            repeat (idx % 4) @(posedge clk);        // Uneven idle gaps
        end
        while (redirect_pending) @(posedge clk);    // Last target word has to arrive
        repeat (10) @(posedge clk);
        if (words == 0) begin
            errors++;
            $display("No instruction word was delivered during the run");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
